/* compile.f */
+incdir+dv
src/bbc_pkg.sv
src/sheila_regs.sv
src/disp_addr_xlate.sv
src/video_slot_arbiter.sv
src/bbc_mem_bus.sv
dv/tb_bbc_mem_bus.sv

/* dv/tb_vectors.svh */
// Columns: kind, model, addr, wdata, sync, latch nibble, ma, ra, expected
typedef enum {K_WR, K_RD, K_LATCH, K_SHADOW, K_DISP} kind_e;

typedef struct {
	kind_e           kind;
	bbc_pkg::model_e model;
	logic [15:0]     addr;
	logic [7:0]      wdata;
	logic            sync;
	logic [3:0]      latch;
	logic [13:0]     ma;
	logic [4:0]      ra;
	logic [7:0]      exp;
} vec_t;

vec_t vecs[$];

task automatic add_vec(input kind_e k, input bbc_pkg::model_e m, input logic [15:0] a,
	input logic [7:0] d, input logic s, input logic [3:0] l, input logic [13:0] ma,
	input logic [4:0] ra, input logic [7:0] e);
	vec_t v;
	v = '{k, m, a, d, s, l, ma, ra, e};
	vecs.push_back(v);
endtask

task automatic load_vectors;
	// ROMSEL, ACCCON and FDCON writes with readback
	add_vec(K_WR, bbc_pkg::MODEL_B, 16'hFE30, 8'h8F, 0, 4'h0, 14'h0, 5'h0, 8'h0F);
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE31, 8'h8F, 0, 4'h0, 14'h0, 5'h0, 8'h8F);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'hFE32, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h8F);
	add_vec(K_RD, bbc_pkg::MODEL_B, 16'hFE30, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE34, 8'hA5, 0, 4'h0, 14'h0, 5'h0, 8'hA5);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'hFE37, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'hA5);
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE24, 8'h35, 0, 4'h0, 14'h0, 5'h0, 8'h73);
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE25, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h7C);
	add_vec(K_WR, bbc_pkg::MODEL_B, 16'hFE24, 8'h35, 0, 4'h0, 14'h0, 5'h0, 8'h7C);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'hFC10, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'hFE00, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'h1234, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h26);
	add_vec(K_RD, bbc_pkg::MODEL_MASTER, 16'hABCD, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h66);
	// Shadow with ACCCON x set
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h3000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h01);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h7FFF, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h01);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h2FFF, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h8000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	// Only e set, so vdu_op decides
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE34, 8'h02, 0, 4'h0, 14'h0, 5'h0, 8'h02);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h5000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'hC123, 8'h00, 1, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h5000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h01);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h5000, 8'h00, 1, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h5000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'hD000, 8'h00, 1, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h8000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h3000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h01);
	add_vec(K_WR, bbc_pkg::MODEL_MASTER, 16'hFE34, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	add_vec(K_SHADOW, bbc_pkg::MODEL_MASTER, 16'h3000, 8'h00, 0, 4'h0, 14'h0, 5'h0, 8'h00);
	// IC32 bits, ending in wrap mode 4/5
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'hF, 14'h0, 5'h0, 8'h80);
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'hE, 14'h0, 5'h0, 8'hC0);
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'hD, 14'h0, 5'h0, 8'hE0);
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'hC, 14'h0, 5'h0, 8'hF0);
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h7, 14'h0, 5'h0, 8'h70);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h1234, 5'h05, 8'hCC);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0234, 5'h05, 8'hB4);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0000, 5'h00, 8'h00);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0001, 5'h02, 8'h0A);
	// Mode 0/1/2
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h4, 14'h0, 5'h0, 8'h60);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h1A7F, 5'h03, 8'hF8);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0A7F, 5'h03, 8'hA8);
	// Mode 3
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h5, 14'h0, 5'h0, 8'h40);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h1501, 5'h07, 8'h67);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0501, 5'h07, 8'h27);
	// Mode 6, then teletext
	add_vec(K_LATCH, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'hC, 14'h0, 5'h0, 8'h50);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h1FC0, 5'h01, 8'h5F);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h0FC0, 5'h01, 8'h7F);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h23A5, 5'h00, 8'h9A);
	add_vec(K_DISP, bbc_pkg::MODEL_MASTER, 16'h0, 8'h0, 0, 4'h0, 14'h3312, 5'h00, 8'h6D);
endtask

/* dv/tb_bbc_mem_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bbc_mem_bus;

	localparam int CLK_PERIOD = 100;
	localparam int DLY = 2;

	logic                       clk;
	logic                       reset_n;
	bbc_pkg::model_e            model_i;
	bbc_pkg::cpu_bus_t          cpu_i;
	logic [3:0]                 latch_i;
	logic                       phi0_i;
	bbc_pkg::crtc_addr_t        crtc_i;
	logic                       disp_valid_i;
	logic                       disp_ready_o;
	logic [7:0]                 mem_di_i;
	logic [15:0]                mem_adr_o;
	logic                       mem_we_o;
	logic [7:0]                 mem_do_o;
	logic [7:0]                 romsel_o;
	bbc_pkg::acccon_t           acccon_o;
	bbc_pkg::fdcon_t            fdcon_o;
	bbc_pkg::sys_latch_t        sys_latch_o;
	logic                       shadow_ram_o;
	logic [7:0]                 cpu_rdata_o;
	logic [7:0]                 vid_data_o;
	logic                       vid_valid_o;
	logic                       vid_ready_i;

	int         err_count;
	int         disp_sent;
	int         disp_seen;
	int         stall;
	logic [7:0] exp_q[$];

	`include "tb_vectors.svh"

	bbc_mem_bus uut (
		.CLK32M_I     (clk),
		.reset_n      (reset_n),
		.model_i      (model_i),
		.cpu_i        (cpu_i),
		.latch_i      (latch_i),
		.phi0_i       (phi0_i),
		.crtc_i       (crtc_i),
		.disp_valid_i (disp_valid_i),
		.disp_ready_o (disp_ready_o),
		.mem_di_i     (mem_di_i),
		.mem_adr_o    (mem_adr_o),
		.mem_we_o     (mem_we_o),
		.mem_do_o     (mem_do_o),
		.romsel_o     (romsel_o),
		.acccon_o     (acccon_o),
		.fdcon_o      (fdcon_o),
		.sys_latch_o  (sys_latch_o),
		.shadow_ram_o (shadow_ram_o),
		.cpu_rdata_o  (cpu_rdata_o),
		.vid_data_o   (vid_data_o),
		.vid_valid_o  (vid_valid_o),
		.vid_ready_i  (vid_ready_i)
	);

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			err_count++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic idle_bus;
		cpu_i = '{addr: 16'h0000, wdata: 8'h00, r_nw: 1'b1, sync: 1'b0, clken: 1'b0};
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// RAM returns low XOR high address byte one cycle later
	always @(posedge clk) begin
		mem_di_i <= mem_adr_o[7:0] ^ mem_adr_o[15:8];
	end

	always @(posedge clk) begin
		#DLY phi0_i = ~phi0_i;
	end

	// Random back-pressure on the video output
	always @(posedge clk) begin
		#DLY;
		if (stall > 0) begin
			stall--;
			vid_ready_i = 1'b0;
		end else if ($urandom % 4 == 0) begin
			stall = $urandom % 6;
			vid_ready_i = 1'b0;
		end else begin
			vid_ready_i = 1'b1;
		end
	end

	// Video results leave in order
	always @(negedge clk) begin
		if (reset_n && vid_valid_o && vid_ready_i) begin
			disp_seen++;
			if (exp_q.size() == 0) begin
				err_count++;
				$display("Error at %0t ns: video data came out with no fetch outstanding", $time);
			end else begin
				check_val("vid_data_o", {8'h00, exp_q.pop_front()}, {8'h00, vid_data_o});
			end
		end
	end

	// RAM port sharing by phi0
	always @(negedge clk) begin
		if (phi0_i) begin
			check_val("mem_adr_o", cpu_i.addr, mem_adr_o);
			check_val("mem_we_o", {15'h0, ~cpu_i.r_nw}, {15'h0, mem_we_o});
			if (!cpu_i.r_nw) begin
				check_val("mem_do_o", {8'h00, cpu_i.wdata}, {8'h00, mem_do_o});
			end
		end else begin
			check_val("mem_we_o", 16'h0000, {15'h0, mem_we_o});
		end
	end

	initial begin
		@(posedge reset_n);
		#(vecs.size() * 40 * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", vecs.size() * 40);
		$display("Test failed");
		$finish;
	end

	initial begin
		vec_t v;
		void'($urandom(32'h4201_cbef));
		err_count = 0;
		disp_sent = 0;
		disp_seen = 0;
		stall = 0;
		reset_n = 1'b0;
		model_i = bbc_pkg::MODEL_MASTER;
		idle_bus();
		latch_i = 4'h0;
		phi0_i = 1'b0;
		crtc_i = '0;
		disp_valid_i = 1'b0;
		vid_ready_i = 1'b1;
		mem_di_i = 8'h00;
		load_vectors();
		repeat (3) @(posedge clk);
		#DLY;
		check_val("romsel_o", 16'h0000, {8'h00, romsel_o});
		check_val("acccon_o", 16'h0000, {8'h00, acccon_o});
		check_val("fdcon_o", 16'h0078, {9'h000, fdcon_o});
		check_val("sys_latch_o", 16'h0000, {8'h00, sys_latch_o});
		check_val("vid_valid_o", 16'h0000, {15'h0, vid_valid_o});
		check_val("disp_ready_o", 16'h0000, {15'h0, disp_ready_o});
		reset_n = 1'b1;
		@(posedge clk);
		#DLY;
		check_val("disp_ready_o", 16'h0001, {15'h0, disp_ready_o});

		foreach (vecs[i]) begin
			v = vecs[i];
			@(posedge clk);
			#DLY;
			model_i = v.model;
			case (v.kind)
				K_WR: begin
					cpu_i = '{addr: v.addr, wdata: v.wdata, r_nw: 1'b0, sync: 1'b0, clken: 1'b1};
					// Write spans both phi0 phases
					repeat (2) @(posedge clk);
					#DLY;
					idle_bus();
					if (v.addr[15:2] == bbc_pkg::FDCON_BASE[15:2]) begin
						check_val("fdcon_o", {8'h00, v.exp}, {9'h000, fdcon_o});
					end else if (v.addr[15:2] == bbc_pkg::ACCCON_BASE[15:2]) begin
						check_val("acccon_o", {8'h00, v.exp}, {8'h00, acccon_o});
					end else begin
						check_val("romsel_o", {8'h00, v.exp}, {8'h00, romsel_o});
					end
				end
				K_RD: begin
					cpu_i = '{addr: v.addr, wdata: 8'h00, r_nw: 1'b1, sync: 1'b0, clken: 1'b1};
					@(negedge clk);
					while (!phi0_i) @(negedge clk);
					@(negedge clk);
					check_val("cpu_rdata_o", {8'h00, v.exp}, {8'h00, cpu_rdata_o});
				end
				K_LATCH: begin
					latch_i = v.latch;
					@(posedge clk);
					#DLY;
					latch_i = 4'h0;
					check_val("sys_latch_o", {8'h00, v.exp}, {8'h00, sys_latch_o});
				end
				K_SHADOW: begin
					cpu_i = '{addr: v.addr, wdata: 8'h00, r_nw: 1'b1, sync: v.sync, clken: 1'b1};
					@(negedge clk);
					check_val("shadow_ram_o", {8'h00, v.exp}, {15'h0, shadow_ram_o});
					// Let the edge update vdu_op before the bus goes idle
					@(posedge clk);
					#DLY;
					idle_bus();
				end
				default: begin
					crtc_i = '{ma: v.ma, ra: v.ra};
					disp_valid_i = 1'b1;
					@(negedge clk);
					while (!disp_ready_o) @(negedge clk);
					exp_q.push_back(v.exp);
					disp_sent++;
					@(posedge clk);
					#DLY;
					disp_valid_i = 1'b0;
				end
			endcase
		end

		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		check_val("video result count", disp_sent[15:0], disp_seen[15:0]);
		$display("Errors: %0d, display fetches: %0d sent, %0d received",
			err_count, disp_sent, disp_seen);
		if (err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# Build with Verilator and run; pass is decided by the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_bbc_mem_bus -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Test passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* src/bbc_mem_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module bbc_mem_bus (
	input  wire logic                         CLK32M_I,
	input  wire logic                         reset_n,
	input  wire bbc_pkg::model_e              model_i,
	input  wire bbc_pkg::cpu_bus_t            cpu_i,
	input  wire logic [3:0]                   latch_i,
	input  wire logic                         phi0_i,
	input  wire bbc_pkg::crtc_addr_t          crtc_i,
	input  wire logic                         disp_valid_i,
	output logic                              disp_ready_o,
	input  wire logic [bbc_pkg::DATA_W-1:0]   mem_di_i,
	output logic [bbc_pkg::ADDR_W-1:0]        mem_adr_o,
	output logic                              mem_we_o,
	output logic [bbc_pkg::DATA_W-1:0]        mem_do_o,
	output logic [bbc_pkg::DATA_W-1:0]        romsel_o,
	output bbc_pkg::acccon_t                  acccon_o,
	output bbc_pkg::fdcon_t                   fdcon_o,
	output bbc_pkg::sys_latch_t               sys_latch_o,
	output logic                              shadow_ram_o,
	output logic [bbc_pkg::DATA_W-1:0]        cpu_rdata_o,
	output logic [bbc_pkg::DATA_W-1:0]        vid_data_o,
	output logic                              vid_valid_o,
	input  wire logic                         vid_ready_i
);

	bbc_pkg::sys_latch_t          sys_latch;
	logic [bbc_pkg::DISP_A_W-1:0] xlate_addr;
	logic                         xlate_valid;
	logic                         xlate_ready;

	sheila_regs u_sheila_regs (
		.CLK32M_I     (CLK32M_I),
		.reset_n      (reset_n),
		.model_i      (model_i),
		.cpu_i        (cpu_i),
		.latch_i      (latch_i),
		.mem_di_i     (mem_di_i),
		.romsel_o     (romsel_o),
		.acccon_o     (acccon_o),
		.fdcon_o      (fdcon_o),
		.sys_latch_o  (sys_latch),
		.shadow_ram_o (shadow_ram_o),
		.cpu_rdata_o  (cpu_rdata_o)
	);

	// Screen mode wrap comes from IC32 bits 5 and 4
	disp_addr_xlate u_disp_addr_xlate (
		.CLK32M_I    (CLK32M_I),
		.reset_n     (reset_n),
		.wrap_i      (sys_latch.wrap),
		.crtc_i      (crtc_i),
		.in_valid_i  (disp_valid_i),
		.in_ready_o  (disp_ready_o),
		.addr_o      (xlate_addr),
		.out_valid_o (xlate_valid),
		.out_ready_i (xlate_ready)
	);

	video_slot_arbiter u_video_slot_arbiter (
		.CLK32M_I     (CLK32M_I),
		.reset_n      (reset_n),
		.phi0_i       (phi0_i),
		.cpu_i        (cpu_i),
		.disp_addr_i  (xlate_addr),
		.disp_valid_i (xlate_valid),
		.disp_ready_o (xlate_ready),
		.mem_di_i     (mem_di_i),
		.mem_adr_o    (mem_adr_o),
		.mem_we_o     (mem_we_o),
		.mem_do_o     (mem_do_o),
		.vid_data_o   (vid_data_o),
		.vid_valid_o  (vid_valid_o),
		.vid_ready_i  (vid_ready_i)
	);

	assign sys_latch_o = sys_latch;

endmodule

`default_nettype wire

/* src/bbc_pkg.sv */
`default_nettype none

package bbc_pkg;

	// Bus widths
	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 8;
	localparam int DISP_A_W = 15;

	// SHEILA registers, each decoded on four addresses
	localparam logic [ADDR_W-1:0] ROMSEL_BASE = 16'hFE30;
	localparam logic [ADDR_W-1:0] ACCCON_BASE = 16'hFE34;
	localparam logic [ADDR_W-1:0] FDCON_BASE  = 16'hFE24;

	// FRED, JIM and SHEILA start here
	localparam logic [ADDR_W-1:0] IO_BASE = 16'hFC00;

	// Master shadow window
	localparam logic [ADDR_W-1:0] SHADOW_LO = 16'h3000;
	localparam logic [ADDR_W-1:0] SHADOW_HI = 16'h7FFF;

	// Opcode fetches from C000-DFFF mark VDU driver code
	localparam logic [2:0] VDU_PAGE = 3'b110;

	typedef enum logic {
		MODEL_B      = 1'b0,
		MODEL_MASTER = 1'b1
	} model_e;

	// Offset added to MA[11:8] when the CRTC address wraps past 0x8000
	typedef enum logic [1:0] {
		WRAP_MODE3   = 2'b00,
		WRAP_MODE6   = 2'b01,
		WRAP_MODE012 = 2'b10,
		WRAP_MODE45  = 2'b11
	} wrap_mode_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              r_nw;
		logic              sync;
		logic              clken;
	} cpu_bus_t;

	typedef struct packed {
		logic irr;
		logic tst;
		logic ifj;
		logic itu;
		logic y;
		logic x;
		logic e;
		logic d;
	} acccon_t;

	typedef struct packed {
		logic [3:0] drive;
		logic       side;
		logic       reset;
		logic       density;
	} fdcon_t;

	// IC32 addressable latch; low nibble fed sound, speech and keyboard
	typedef struct packed {
		logic       shift_led_n;
		logic       caps_led_n;
		wrap_mode_e wrap;
		logic [3:0] unused;
	} sys_latch_t;

	typedef struct packed {
		logic [13:0] ma;
		logic [4:0]  ra;
	} crtc_addr_t;

endpackage

`default_nettype wire

/* src/disp_addr_xlate.sv */
`timescale 1ns/1ns
`default_nettype none

module disp_addr_xlate (
	input  wire logic                         CLK32M_I,
	input  wire logic                         reset_n,
	input  wire bbc_pkg::wrap_mode_e          wrap_i,
	input  wire bbc_pkg::crtc_addr_t          crtc_i,
	input  wire logic                         in_valid_i,
	output logic                              in_ready_o,
	output logic [bbc_pkg::DISP_A_W-1:0]      addr_o,
	output logic                              out_valid_o,
	input  wire logic                         out_ready_i
);

	logic [3:0]                  offset;
	logic [3:0]                  nibble;
	logic [bbc_pkg::DISP_A_W-1:0] xlate_addr;
	logic [bbc_pkg::DISP_A_W-1:0] addr_q;
	logic                        valid_q;
	logic                        run_q;

	// Offset that brings a wrapped address back to the screen start
	always_comb begin
		case (wrap_i)
			bbc_pkg::WRAP_MODE3:   offset = 4'd8;
			bbc_pkg::WRAP_MODE6:   offset = 4'd12;
			bbc_pkg::WRAP_MODE012: offset = 4'd6;
			bbc_pkg::WRAP_MODE45:  offset = 4'd11;
			default:               offset = 4'd0;
		endcase
	end

	assign nibble = crtc_i.ma[12] ? (crtc_i.ma[11:8] + offset) : crtc_i.ma[11:8];

	// MA13 selects the teletext frame at 7C00
	assign xlate_addr = crtc_i.ma[13] ? {nibble[3], 4'b1111, crtc_i.ma[9:0]}
		: {nibble, crtc_i.ma[7:0], crtc_i.ra[2:0]};

	// Input side opens the cycle after reset is released
	assign in_ready_o = run_q & (~valid_q | out_ready_i);

	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			run_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (in_ready_o) begin
				valid_q <= in_valid_i;
			end
		end
	end

	always_ff @(posedge CLK32M_I) begin
		if (in_ready_o && in_valid_i) begin
			addr_q <= xlate_addr;
		end
	end

	assign addr_o = addr_q;
	assign out_valid_o = valid_q;

endmodule

`default_nettype wire

/* src/sheila_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module sheila_regs (
	input  wire logic                       CLK32M_I,
	input  wire logic                       reset_n,
	input  wire bbc_pkg::model_e            model_i,
	input  wire bbc_pkg::cpu_bus_t          cpu_i,
	input  wire logic [3:0]                 latch_i,
	input  wire logic [bbc_pkg::DATA_W-1:0] mem_di_i,
	output logic [bbc_pkg::DATA_W-1:0]      romsel_o,
	output bbc_pkg::acccon_t                acccon_o,
	output bbc_pkg::fdcon_t                 fdcon_o,
	output bbc_pkg::sys_latch_t             sys_latch_o,
	output logic                            shadow_ram_o,
	output logic [bbc_pkg::DATA_W-1:0]      cpu_rdata_o
);

	logic [bbc_pkg::DATA_W-1:0] romsel_q;
	bbc_pkg::acccon_t           acccon_q;
	bbc_pkg::fdcon_t            fdcon_q;
	logic [7:0]                 ic32_q;
	logic                       vdu_op_q;

	logic is_master;
	logic romsel_sel;
	logic acccon_sel;
	logic fdcon_sel;
	logic cpu_wr;
	logic in_window;

	assign is_master = (model_i == bbc_pkg::MODEL_MASTER);

	// Low two address bits are not decoded
	assign romsel_sel = (cpu_i.addr[bbc_pkg::ADDR_W-1:2] ==
		bbc_pkg::ROMSEL_BASE[bbc_pkg::ADDR_W-1:2]);
	assign acccon_sel = (cpu_i.addr[bbc_pkg::ADDR_W-1:2] ==
		bbc_pkg::ACCCON_BASE[bbc_pkg::ADDR_W-1:2]);
	assign fdcon_sel = (cpu_i.addr[bbc_pkg::ADDR_W-1:2] ==
		bbc_pkg::FDCON_BASE[bbc_pkg::ADDR_W-1:2]);

	assign cpu_wr = cpu_i.clken & ~cpu_i.r_nw;

	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			romsel_q <= '0;
			acccon_q <= '0;
			fdcon_q <= '{drive: 4'b1111, side: 1'b0, reset: 1'b0, density: 1'b0};
			vdu_op_q <= 1'b0;
		end else begin
			if (cpu_wr && romsel_sel) begin
				// Model B has no bit 7 on the paged ROM latch
				romsel_q <= {cpu_i.wdata[7] & is_master, cpu_i.wdata[6:0]};
			end
			if (cpu_wr && acccon_sel) begin
				acccon_q <= bbc_pkg::acccon_t'(cpu_i.wdata);
			end
			if (cpu_wr && fdcon_sel && is_master) begin
				fdcon_q.drive <= {3'b111, ~cpu_i.wdata[0]};
				fdcon_q.reset <= cpu_i.wdata[2];
				fdcon_q.side <= ~cpu_i.wdata[4];
				fdcon_q.density <= cpu_i.wdata[5];
			end
			// Remember whether the last opcode came from the VDU page
			if (cpu_i.clken && cpu_i.sync) begin
				vdu_op_q <= (cpu_i.addr[bbc_pkg::ADDR_W-1:bbc_pkg::ADDR_W-3] ==
					bbc_pkg::VDU_PAGE);
			end
		end
	end

	// IC32 is written every cycle from system VIA port B
	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			ic32_q <= '0;
		end else begin
			ic32_q[latch_i[2:0]] <= latch_i[3];
		end
	end

	assign in_window = (cpu_i.addr >= bbc_pkg::SHADOW_LO) &&
		(cpu_i.addr <= bbc_pkg::SHADOW_HI);

	// Shadow is always on with X; with E only for VDU code data accesses
	assign shadow_ram_o = in_window &
		(acccon_q.x | (acccon_q.e & vdu_op_q & ~cpu_i.sync));

	always_comb begin
		if (acccon_sel) begin
			cpu_rdata_o = acccon_q;
		end else if (romsel_sel && is_master) begin
			cpu_rdata_o = romsel_q;
		end else if (cpu_i.addr >= bbc_pkg::IO_BASE) begin
			// Undecoded I/O is pulled low
			cpu_rdata_o = '0;
		end else begin
			cpu_rdata_o = mem_di_i;
		end
	end

	assign romsel_o = romsel_q;
	assign acccon_o = acccon_q;
	assign fdcon_o = fdcon_q;
	assign sys_latch_o = bbc_pkg::sys_latch_t'(ic32_q);

endmodule

`default_nettype wire

/* src/video_slot_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module video_slot_arbiter (
	input  wire logic                          CLK32M_I,
	input  wire logic                          reset_n,
	input  wire logic                          phi0_i,
	input  wire bbc_pkg::cpu_bus_t             cpu_i,
	input  wire logic [bbc_pkg::DISP_A_W-1:0]  disp_addr_i,
	input  wire logic                          disp_valid_i,
	output logic                               disp_ready_o,
	input  wire logic [bbc_pkg::DATA_W-1:0]    mem_di_i,
	output logic [bbc_pkg::ADDR_W-1:0]         mem_adr_o,
	output logic                               mem_we_o,
	output logic [bbc_pkg::DATA_W-1:0]         mem_do_o,
	output logic [bbc_pkg::DATA_W-1:0]         vid_data_o,
	output logic                               vid_valid_o,
	input  wire logic                          vid_ready_i
);

	// Address slot
	logic [bbc_pkg::DISP_A_W-1:0] addr_q;
	logic                         addr_full_q;

	// Read issued last cycle, data arrives now
	logic pend_q;

	// Data slot
	logic [bbc_pkg::DATA_W-1:0] data_q;
	logic                       data_full_q;

	logic accept;
	logic issue;

	assign disp_ready_o = ~addr_full_q;
	assign accept = disp_valid_i & ~addr_full_q;

	// Video owns the RAM in the low half of phi0
	assign issue = ~phi0_i & addr_full_q & ~data_full_q & ~pend_q;

	always_ff @(posedge CLK32M_I) begin
		if (!reset_n) begin
			addr_full_q <= 1'b0;
			pend_q <= 1'b0;
			data_full_q <= 1'b0;
		end else begin
			if (issue) begin
				addr_full_q <= 1'b0;
			end else if (accept) begin
				addr_full_q <= 1'b1;
			end
			pend_q <= issue;
			if (pend_q) begin
				data_full_q <= 1'b1;
			end else if (data_full_q && vid_ready_i) begin
				data_full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK32M_I) begin
		if (accept) begin
			addr_q <= disp_addr_i;
		end
		if (pend_q) begin
			data_q <= mem_di_i;
		end
	end

	// RAM port shared by phi0
	assign mem_adr_o = phi0_i ? cpu_i.addr
		: {{(bbc_pkg::ADDR_W-bbc_pkg::DISP_A_W){1'b0}}, addr_q};
	assign mem_we_o = phi0_i & ~cpu_i.r_nw;
	assign mem_do_o = cpu_i.wdata;

	assign vid_data_o = data_q;
	assign vid_valid_o = data_full_q;

endmodule

`default_nettype wire
